// ==== lc4_isa_pkg.sv ====
package lc4_isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    // top four instruction bits
    typedef enum logic [3:0] {
        OP_NOP     = 4'b0000,
        OP_ARITH   = 4'b0001,
        OP_LOGIC   = 4'b0101,
        OP_CONST   = 4'b1001,
        OP_HICONST = 4'b1101
    } opcode_e;

    // register-form sub-op, bits 5:3 with opcode bit 14 in front
    // so that the arith and logic groups stay distinct
    typedef enum logic [3:0] {
        SUB_ADD = 4'b0000,
        SUB_SUB = 4'b0010,
        SUB_AND = 4'b1000,
        SUB_OR  = 4'b1010,
        SUB_XOR = 4'b1011
    } alu_sub_e;

    localparam int OP_HI   = 15;
    localparam int OP_LO   = 12;
    localparam int RD_HI   = 11;
    localparam int RD_LO   = 9;
    localparam int RS_HI   = 8;
    localparam int RS_LO   = 6;
    localparam int RT_HI   = 2;
    localparam int RT_LO   = 0;
    localparam int IMM_BIT = 5;
    localparam int GRP_BIT = 14;
    localparam int IMM5_HI = 4;
    localparam int IMM8_HI = 7;
    localparam int IMM9_HI = 8;

endpackage

// ==== lc4_pipe_pkg.sv ====
package lc4_pipe_pkg;

    localparam int NUM_REGS = 8;

    // writeback stall code
    typedef enum logic [1:0] {
        STALL_NONE        = 2'd0,
        STALL_SUPERSCALAR = 2'd1,
        STALL_EMPTY       = 2'd2
    } stall_e;

endpackage

// ==== lc4_decoder.sv ====
`timescale 1ns/10ps
module lc4_decoder
    import lc4_isa_pkg::*;
(
    input  word_t    i_insn,
    output opcode_e  o_opcode,
    output reg_idx_t o_rs,
    output reg_idx_t o_rt,
    output reg_idx_t o_rd,
    output logic     o_rs_re,
    output logic     o_rt_re,
    output logic     o_we
);

    opcode_e op;

    assign op       = opcode_e'(i_insn[OP_HI:OP_LO]);
    assign o_opcode = op;
    assign o_rd     = i_insn[RD_HI:RD_LO];
    assign o_rt     = i_insn[RT_HI:RT_LO];
    // hiconst reads its own destination through the rs port
    assign o_rs     = (op == OP_HICONST) ? i_insn[RD_HI:RD_LO] : i_insn[RS_HI:RS_LO];

    always_comb begin
        o_rs_re = 1'b0;
        o_rt_re = 1'b0;
        o_we    = 1'b0;
        case (op)
            OP_ARITH, OP_LOGIC: begin
                o_rs_re = 1'b1;
                o_rt_re = ~i_insn[IMM_BIT];
                o_we    = 1'b1;
            end
            OP_HICONST: begin
                o_rs_re = 1'b1;
                o_we    = 1'b1;
            end
            OP_CONST: o_we = 1'b1;
            default: o_we = 1'b0;
        endcase
    end

endmodule

// ==== lc4_fetch_issue.sv ====
`timescale 1ns/10ps
module lc4_fetch_issue
    import lc4_isa_pkg::*;
#(
    parameter word_t RESET_PC = 16'h8200
) (
    input  logic     i_arst_n,
    input  logic     gwe,
    input  word_t    i_insn_a,
    input  word_t    i_insn_b,
    output word_t    o_cur_pc,
    output logic     o_d_valid_a,
    output word_t    o_d_pc_a,
    output word_t    o_d_insn_a,
    output reg_idx_t o_d_rs_a,
    output reg_idx_t o_d_rt_a,
    output reg_idx_t o_d_rd_a,
    output logic     o_d_rs_re_a,
    output logic     o_d_rt_re_a,
    output logic     o_d_we_a,
    output logic     o_d_held_a,
    output logic     o_d_valid_b,
    output word_t    o_d_pc_b,
    output word_t    o_d_insn_b,
    output reg_idx_t o_d_rs_b,
    output reg_idx_t o_d_rt_b,
    output reg_idx_t o_d_rd_b,
    output logic     o_d_rs_re_b,
    output logic     o_d_rt_re_b,
    output logic     o_d_we_b,
    output logic     o_d_held_b
);

    word_t   pc;
    opcode_e op_a;
    opcode_e op_b;
    logic    b_needs_a;
    logic    pipe_switch;

    lc4_decoder u_dec_a (
        .i_insn(o_d_insn_a), .o_opcode(op_a), .o_rs(o_d_rs_a), .o_rt(o_d_rt_a),
        .o_rd(o_d_rd_a), .o_rs_re(o_d_rs_re_a), .o_rt_re(o_d_rt_re_a), .o_we(o_d_we_a)
    );

    lc4_decoder u_dec_b (
        .i_insn(o_d_insn_b), .o_opcode(op_b), .o_rs(o_d_rs_b), .o_rt(o_d_rt_b),
        .o_rd(o_d_rd_b), .o_rs_re(o_d_rs_re_b), .o_rt_re(o_d_rt_re_b), .o_we(o_d_we_b)
    );

    // B reads what A writes in the same pair
    assign b_needs_a = o_d_valid_a && o_d_we_a && op_a != OP_NOP && op_b != OP_NOP &&
                       ((o_d_rs_re_b && o_d_rs_b == o_d_rd_a) ||
                        (o_d_rt_re_b && o_d_rt_b == o_d_rd_a));
    assign pipe_switch = b_needs_a || !o_d_valid_a;

    // slot A always issues, B sits out on a switch
    assign o_d_held_a = 1'b0;
    assign o_d_held_b = pipe_switch;
    assign o_cur_pc   = pc;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc          <= RESET_PC;
            o_d_valid_a <= 1'b0;
            o_d_valid_b <= 1'b0;
        end else if (pipe_switch) begin
            pc          <= pc + 16'd1;
            o_d_valid_a <= o_d_valid_b;
            o_d_valid_b <= 1'b1;
        end else begin
            pc          <= pc + 16'd2;
            o_d_valid_a <= 1'b1;
            o_d_valid_b <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (pipe_switch) begin
            o_d_pc_a   <= o_d_pc_b;
            o_d_insn_a <= o_d_insn_b;
            o_d_pc_b   <= pc;
            o_d_insn_b <= i_insn_a;
        end else begin
            o_d_pc_a   <= pc;
            o_d_insn_a <= i_insn_a;
            o_d_pc_b   <= pc + 16'd1;
            o_d_insn_b <= i_insn_b;
        end
    end

endmodule

// ==== lc4_regfile_2w.sv ====
`timescale 1ns/10ps
module lc4_regfile_2w
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
    input  logic     i_arst_n,
    input  logic     gwe,
    input  reg_idx_t i_rs_a,
    input  reg_idx_t i_rt_a,
    input  reg_idx_t i_rs_b,
    input  reg_idx_t i_rt_b,
    output word_t    o_rs_data_a,
    output word_t    o_rt_data_a,
    output word_t    o_rs_data_b,
    output word_t    o_rt_data_b,
    input  reg_idx_t i_rd_a,
    input  word_t    i_wdata_a,
    input  logic     i_we_a,
    input  reg_idx_t i_rd_b,
    input  word_t    i_wdata_b,
    input  logic     i_we_b
);

    word_t regs [NUM_REGS];

    // write-through, B is younger so it is checked first
    function automatic word_t rd_port(input reg_idx_t idx);
        if (i_we_b && i_rd_b == idx) return i_wdata_b;
        if (i_we_a && i_rd_a == idx) return i_wdata_a;
        return regs[idx];
    endfunction

    always_comb begin
        o_rs_data_a = rd_port(i_rs_a);
        o_rt_data_a = rd_port(i_rt_a);
        o_rs_data_b = rd_port(i_rs_b);
        o_rt_data_b = rd_port(i_rt_b);
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
        end else begin
            if (i_we_a) regs[i_rd_a] <= i_wdata_a;
            // later write wins on a collision
            if (i_we_b) regs[i_rd_b] <= i_wdata_b;
        end
    end

endmodule

// ==== lc4_bypass_unit.sv ====
`timescale 1ns/10ps
module lc4_bypass_unit
    import lc4_isa_pkg::*;
(
    input  reg_idx_t i_x_rs_a,
    input  reg_idx_t i_x_rt_a,
    input  reg_idx_t i_x_rs_b,
    input  reg_idx_t i_x_rt_b,
    input  logic     i_x_rs_re_a,
    input  logic     i_x_rt_re_a,
    input  logic     i_x_rs_re_b,
    input  logic     i_x_rt_re_b,
    input  reg_idx_t i_m_rd_a,
    input  reg_idx_t i_m_rd_b,
    input  logic     i_m_we_a,
    input  logic     i_m_we_b,
    input  word_t    i_m_val_a,
    input  word_t    i_m_val_b,
    input  reg_idx_t i_w_rd_a,
    input  reg_idx_t i_w_rd_b,
    input  logic     i_w_we_a,
    input  logic     i_w_we_b,
    input  word_t    i_w_val_a,
    input  word_t    i_w_val_b,
    input  word_t    i_rf_rs_a,
    input  word_t    i_rf_rt_a,
    input  word_t    i_rf_rs_b,
    input  word_t    i_rf_rt_b,
    output word_t    o_op1_a,
    output word_t    o_op2_a,
    output word_t    o_op1_b,
    output word_t    o_op2_b
);

    // youngest producer first: M-B, M-A, W-B, W-A
    function automatic word_t pick(input reg_idx_t src, input logic re, input word_t rf);
        if (re && i_m_we_b && i_m_rd_b == src) return i_m_val_b;
        if (re && i_m_we_a && i_m_rd_a == src) return i_m_val_a;
        if (re && i_w_we_b && i_w_rd_b == src) return i_w_val_b;
        if (re && i_w_we_a && i_w_rd_a == src) return i_w_val_a;
        return rf;
    endfunction

    always_comb begin
        o_op1_a = pick(i_x_rs_a, i_x_rs_re_a, i_rf_rs_a);
        o_op2_a = pick(i_x_rt_a, i_x_rt_re_a, i_rf_rt_a);
        o_op1_b = pick(i_x_rs_b, i_x_rs_re_b, i_rf_rs_b);
        o_op2_b = pick(i_x_rt_b, i_x_rt_re_b, i_rf_rt_b);
    end

endmodule

// ==== lc4_alu.sv ====
`timescale 1ns/10ps
module lc4_alu
    import lc4_isa_pkg::*;
(
    input  word_t i_insn,
    input  word_t i_r1,
    input  word_t i_r2,
    output word_t o_result
);

    word_t    imm5;
    word_t    imm9;
    alu_sub_e sub;

    assign imm5 = {{11{i_insn[IMM5_HI]}}, i_insn[IMM5_HI:0]};
    assign imm9 = {{7{i_insn[IMM9_HI]}}, i_insn[IMM9_HI:0]};
    assign sub  = alu_sub_e'({i_insn[GRP_BIT], i_insn[IMM_BIT:3]});

    always_comb begin
        o_result = '0;
        case (opcode_e'(i_insn[OP_HI:OP_LO]))
            OP_ARITH, OP_LOGIC: begin
                if (i_insn[IMM_BIT]) begin
                    // immediate form, group bit picks add or and
                    o_result = i_insn[GRP_BIT] ? (i_r1 & imm5) : (i_r1 + imm5);
                end else begin
                    case (sub)
                        SUB_ADD: o_result = i_r1 + i_r2;
                        SUB_SUB: o_result = i_r1 - i_r2;
                        SUB_AND: o_result = i_r1 & i_r2;
                        SUB_OR:  o_result = i_r1 | i_r2;
                        SUB_XOR: o_result = i_r1 ^ i_r2;
                        default: o_result = '0;
                    endcase
                end
            end
            OP_CONST:   o_result = imm9;
            OP_HICONST: o_result = {i_insn[IMM8_HI:0], i_r1[7:0]};
            default:    o_result = '0;
        endcase
    end

endmodule

// ==== lc4_exec_pipe.sv ====
`timescale 1ns/10ps
module lc4_exec_pipe
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
    input  logic     i_arst_n,
    input  logic     gwe,
    input  logic     i_d_valid_a,
    input  word_t    i_d_pc_a,
    input  word_t    i_d_insn_a,
    input  reg_idx_t i_d_rs_a,
    input  reg_idx_t i_d_rt_a,
    input  reg_idx_t i_d_rd_a,
    input  logic     i_d_rs_re_a,
    input  logic     i_d_rt_re_a,
    input  logic     i_d_we_a,
    input  logic     i_d_held_a,
    input  logic     i_d_valid_b,
    input  word_t    i_d_pc_b,
    input  word_t    i_d_insn_b,
    input  reg_idx_t i_d_rs_b,
    input  reg_idx_t i_d_rt_b,
    input  reg_idx_t i_d_rd_b,
    input  logic     i_d_rs_re_b,
    input  logic     i_d_rt_re_b,
    input  logic     i_d_we_b,
    input  logic     i_d_held_b,
    input  word_t    i_rs_data_a,
    input  word_t    i_rt_data_a,
    input  word_t    i_rs_data_b,
    input  word_t    i_rt_data_b,
    output reg_idx_t o_rf_rd_a,
    output reg_idx_t o_rf_rd_b,
    output word_t    o_rf_wdata_a,
    output word_t    o_rf_wdata_b,
    output logic     o_rf_we_a,
    output logic     o_rf_we_b,
    output logic     o_wb_valid_a,
    output logic     o_wb_valid_b,
    output stall_e   o_wb_stall_a,
    output stall_e   o_wb_stall_b,
    output word_t    o_wb_pc_a,
    output word_t    o_wb_pc_b,
    output word_t    o_wb_insn_a,
    output word_t    o_wb_insn_b,
    output logic     o_wb_we_a,
    output logic     o_wb_we_b,
    output reg_idx_t o_wb_wsel_a,
    output reg_idx_t o_wb_wsel_b,
    output word_t    o_wb_data_a,
    output word_t    o_wb_data_b
);

    // x stage
    logic     x_valid_a, x_valid_b, x_we_a, x_we_b;
    logic     x_rs_re_a, x_rs_re_b, x_rt_re_a, x_rt_re_b;
    stall_e   x_stall_a, x_stall_b;
    word_t    x_pc_a, x_pc_b, x_insn_a, x_insn_b;
    word_t    x_rs_a_val, x_rt_a_val, x_rs_b_val, x_rt_b_val;
    reg_idx_t x_rs_a, x_rt_a, x_rs_b, x_rt_b, x_rd_a, x_rd_b;
    // m stage
    logic     m_valid_a, m_valid_b, m_we_a, m_we_b;
    stall_e   m_stall_a, m_stall_b;
    word_t    m_pc_a, m_pc_b, m_insn_a, m_insn_b, m_val_a, m_val_b;
    reg_idx_t m_rd_a, m_rd_b;
    // execute operands and results
    word_t    op1_a, op2_a, op1_b, op2_b, res_a, res_b;

    function automatic stall_e code(input logic valid, input logic held);
        if (!valid) return STALL_EMPTY;
        return held ? STALL_SUPERSCALAR : STALL_NONE;
    endfunction

    lc4_bypass_unit u_bypass (
        .i_x_rs_a(x_rs_a), .i_x_rt_a(x_rt_a), .i_x_rs_b(x_rs_b), .i_x_rt_b(x_rt_b),
        .i_x_rs_re_a(x_rs_re_a), .i_x_rt_re_a(x_rt_re_a),
        .i_x_rs_re_b(x_rs_re_b), .i_x_rt_re_b(x_rt_re_b),
        .i_m_rd_a(m_rd_a), .i_m_rd_b(m_rd_b), .i_m_we_a(m_we_a), .i_m_we_b(m_we_b),
        .i_m_val_a(m_val_a), .i_m_val_b(m_val_b),
        .i_w_rd_a(o_wb_wsel_a), .i_w_rd_b(o_wb_wsel_b),
        .i_w_we_a(o_wb_we_a), .i_w_we_b(o_wb_we_b),
        .i_w_val_a(o_wb_data_a), .i_w_val_b(o_wb_data_b),
        .i_rf_rs_a(x_rs_a_val), .i_rf_rt_a(x_rt_a_val),
        .i_rf_rs_b(x_rs_b_val), .i_rf_rt_b(x_rt_b_val),
        .o_op1_a(op1_a), .o_op2_a(op2_a), .o_op1_b(op1_b), .o_op2_b(op2_b)
    );

    lc4_alu u_alu_a (.i_insn(x_insn_a), .i_r1(op1_a), .i_r2(op2_a), .o_result(res_a));
    lc4_alu u_alu_b (.i_insn(x_insn_b), .i_r1(op1_b), .i_r2(op2_b), .o_result(res_b));

    // control state, only valid instructions may write
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            {x_valid_a, x_valid_b, x_we_a, x_we_b} <= '0;
            {m_valid_a, m_valid_b, m_we_a, m_we_b} <= '0;
            {o_wb_valid_a, o_wb_valid_b, o_wb_we_a, o_wb_we_b} <= '0;
            x_stall_a    <= STALL_EMPTY;
            x_stall_b    <= STALL_EMPTY;
            m_stall_a    <= STALL_EMPTY;
            m_stall_b    <= STALL_EMPTY;
            o_wb_stall_a <= STALL_EMPTY;
            o_wb_stall_b <= STALL_EMPTY;
        end else begin
            x_valid_a    <= i_d_valid_a && !i_d_held_a;
            x_valid_b    <= i_d_valid_b && !i_d_held_b;
            x_we_a       <= i_d_valid_a && !i_d_held_a && i_d_we_a;
            x_we_b       <= i_d_valid_b && !i_d_held_b && i_d_we_b;
            x_stall_a    <= code(i_d_valid_a, i_d_held_a);
            x_stall_b    <= code(i_d_valid_b, i_d_held_b);
            m_valid_a    <= x_valid_a;
            m_valid_b    <= x_valid_b;
            m_we_a       <= x_we_a;
            m_we_b       <= x_we_b;
            m_stall_a    <= x_stall_a;
            m_stall_b    <= x_stall_b;
            o_wb_valid_a <= m_valid_a;
            o_wb_valid_b <= m_valid_b;
            o_wb_we_a    <= m_we_a;
            o_wb_we_b    <= m_we_b;
            o_wb_stall_a <= m_stall_a;
            o_wb_stall_b <= m_stall_b;
        end
    end

    // payload, the m stage only carries values onward
    always_ff @(posedge gwe) begin
        {x_pc_a, x_insn_a, x_rd_a, x_rs_a, x_rt_a} <=
            {i_d_pc_a, i_d_insn_a, i_d_rd_a, i_d_rs_a, i_d_rt_a};
        {x_pc_b, x_insn_b, x_rd_b, x_rs_b, x_rt_b} <=
            {i_d_pc_b, i_d_insn_b, i_d_rd_b, i_d_rs_b, i_d_rt_b};
        {x_rs_re_a, x_rt_re_a, x_rs_re_b, x_rt_re_b} <=
            {i_d_rs_re_a, i_d_rt_re_a, i_d_rs_re_b, i_d_rt_re_b};
        {x_rs_a_val, x_rt_a_val} <= {i_rs_data_a, i_rt_data_a};
        {x_rs_b_val, x_rt_b_val} <= {i_rs_data_b, i_rt_data_b};
        {m_pc_a, m_insn_a, m_rd_a, m_val_a} <= {x_pc_a, x_insn_a, x_rd_a, res_a};
        {m_pc_b, m_insn_b, m_rd_b, m_val_b} <= {x_pc_b, x_insn_b, x_rd_b, res_b};
        {o_wb_pc_a, o_wb_insn_a, o_wb_wsel_a, o_wb_data_a} <= {m_pc_a, m_insn_a, m_rd_a, m_val_a};
        {o_wb_pc_b, o_wb_insn_b, o_wb_wsel_b, o_wb_data_b} <= {m_pc_b, m_insn_b, m_rd_b, m_val_b};
    end

    assign o_rf_rd_a    = o_wb_wsel_a;
    assign o_rf_rd_b    = o_wb_wsel_b;
    assign o_rf_wdata_a = o_wb_data_a;
    assign o_rf_wdata_b = o_wb_data_b;
    assign o_rf_we_a    = o_wb_we_a;
    assign o_rf_we_b    = o_wb_we_b;

endmodule

// ==== lc4_core_top.sv ====
`timescale 1ns/10ps
module lc4_core_top
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 16'h8200
) (
    input  logic     i_arst_n,
    input  logic     gwe,
    output word_t    o_cur_pc,
    input  word_t    i_insn_a,
    input  word_t    i_insn_b,
    output logic     o_wb_valid_a,
    output logic     o_wb_valid_b,
    output stall_e   o_wb_stall_a,
    output stall_e   o_wb_stall_b,
    output word_t    o_wb_pc_a,
    output word_t    o_wb_pc_b,
    output word_t    o_wb_insn_a,
    output word_t    o_wb_insn_b,
    output logic     o_wb_we_a,
    output logic     o_wb_we_b,
    output reg_idx_t o_wb_wsel_a,
    output reg_idx_t o_wb_wsel_b,
    output word_t    o_wb_data_a,
    output word_t    o_wb_data_b
);

    logic     d_valid_a, d_valid_b, d_we_a, d_we_b, d_held_a, d_held_b;
    logic     d_rs_re_a, d_rs_re_b, d_rt_re_a, d_rt_re_b;
    word_t    d_pc_a, d_pc_b, d_insn_a, d_insn_b;
    reg_idx_t d_rs_a, d_rs_b, d_rt_a, d_rt_b, d_rd_a, d_rd_b;
    word_t    rs_data_a, rt_data_a, rs_data_b, rt_data_b;
    reg_idx_t rf_rd_a, rf_rd_b;
    word_t    rf_wdata_a, rf_wdata_b;
    logic     rf_we_a, rf_we_b;

    lc4_fetch_issue #(.RESET_PC(RESET_PC)) u_issue (
        .i_arst_n(i_arst_n), .gwe(gwe), .i_insn_a(i_insn_a), .i_insn_b(i_insn_b),
        .o_cur_pc(o_cur_pc),
        .o_d_valid_a(d_valid_a), .o_d_pc_a(d_pc_a), .o_d_insn_a(d_insn_a),
        .o_d_rs_a(d_rs_a), .o_d_rt_a(d_rt_a), .o_d_rd_a(d_rd_a),
        .o_d_rs_re_a(d_rs_re_a), .o_d_rt_re_a(d_rt_re_a), .o_d_we_a(d_we_a),
        .o_d_held_a(d_held_a),
        .o_d_valid_b(d_valid_b), .o_d_pc_b(d_pc_b), .o_d_insn_b(d_insn_b),
        .o_d_rs_b(d_rs_b), .o_d_rt_b(d_rt_b), .o_d_rd_b(d_rd_b),
        .o_d_rs_re_b(d_rs_re_b), .o_d_rt_re_b(d_rt_re_b), .o_d_we_b(d_we_b),
        .o_d_held_b(d_held_b)
    );

    lc4_regfile_2w u_rf (
        .i_arst_n(i_arst_n), .gwe(gwe),
        .i_rs_a(d_rs_a), .i_rt_a(d_rt_a), .i_rs_b(d_rs_b), .i_rt_b(d_rt_b),
        .o_rs_data_a(rs_data_a), .o_rt_data_a(rt_data_a),
        .o_rs_data_b(rs_data_b), .o_rt_data_b(rt_data_b),
        .i_rd_a(rf_rd_a), .i_wdata_a(rf_wdata_a), .i_we_a(rf_we_a),
        .i_rd_b(rf_rd_b), .i_wdata_b(rf_wdata_b), .i_we_b(rf_we_b)
    );

    lc4_exec_pipe u_exec (
        .i_arst_n(i_arst_n), .gwe(gwe),
        .i_d_valid_a(d_valid_a), .i_d_pc_a(d_pc_a), .i_d_insn_a(d_insn_a),
        .i_d_rs_a(d_rs_a), .i_d_rt_a(d_rt_a), .i_d_rd_a(d_rd_a),
        .i_d_rs_re_a(d_rs_re_a), .i_d_rt_re_a(d_rt_re_a), .i_d_we_a(d_we_a),
        .i_d_held_a(d_held_a),
        .i_d_valid_b(d_valid_b), .i_d_pc_b(d_pc_b), .i_d_insn_b(d_insn_b),
        .i_d_rs_b(d_rs_b), .i_d_rt_b(d_rt_b), .i_d_rd_b(d_rd_b),
        .i_d_rs_re_b(d_rs_re_b), .i_d_rt_re_b(d_rt_re_b), .i_d_we_b(d_we_b),
        .i_d_held_b(d_held_b),
        .i_rs_data_a(rs_data_a), .i_rt_data_a(rt_data_a),
        .i_rs_data_b(rs_data_b), .i_rt_data_b(rt_data_b),
        .o_rf_rd_a(rf_rd_a), .o_rf_rd_b(rf_rd_b),
        .o_rf_wdata_a(rf_wdata_a), .o_rf_wdata_b(rf_wdata_b),
        .o_rf_we_a(rf_we_a), .o_rf_we_b(rf_we_b),
        .o_wb_valid_a(o_wb_valid_a), .o_wb_valid_b(o_wb_valid_b),
        .o_wb_stall_a(o_wb_stall_a), .o_wb_stall_b(o_wb_stall_b),
        .o_wb_pc_a(o_wb_pc_a), .o_wb_pc_b(o_wb_pc_b),
        .o_wb_insn_a(o_wb_insn_a), .o_wb_insn_b(o_wb_insn_b),
        .o_wb_we_a(o_wb_we_a), .o_wb_we_b(o_wb_we_b),
        .o_wb_wsel_a(o_wb_wsel_a), .o_wb_wsel_b(o_wb_wsel_b),
        .o_wb_data_a(o_wb_data_a), .o_wb_data_b(o_wb_data_b)
    );

endmodule

// ==== lc4_core_chk.sv ====
`timescale 1ns/10ps
module lc4_core_chk
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
    input logic   i_arst_n,
    input logic   gwe,
    input word_t  i_cur_pc,
    input logic   i_wb_valid_a,
    input logic   i_wb_valid_b,
    input stall_e i_wb_stall_a,
    input stall_e i_wb_stall_b
);

    int fail_count = 0;

    // a retiring slot carries no stall code
    a_stall_a: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_wb_valid_a |-> i_wb_stall_a == STALL_NONE)
        else begin
            $error("slot A retired with a stall code");
            fail_count++;
        end

    a_stall_b: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_wb_valid_b |-> i_wb_stall_b == STALL_NONE)
        else begin
            $error("slot B retired with a stall code");
            fail_count++;
        end

    // B is never older than A, so it cannot retire alone
    a_b_after_a: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_wb_valid_b |-> i_wb_valid_a)
        else begin
            $error("slot B retired without slot A");
            fail_count++;
        end

    // one step on a pipe switch, two otherwise
    a_pc_step: assert property (@(posedge gwe) disable iff (!i_arst_n)
        $past(i_arst_n) |-> (i_cur_pc == word_t'($past(i_cur_pc) + 16'd1) ||
                             i_cur_pc == word_t'($past(i_cur_pc) + 16'd2)))
        else begin
            $error("fetch pc did not step by one or two");
            fail_count++;
        end

endmodule

bind lc4_core_top lc4_core_chk u_chk (
    .i_arst_n(i_arst_n), .gwe(gwe), .i_cur_pc(o_cur_pc),
    .i_wb_valid_a(o_wb_valid_a), .i_wb_valid_b(o_wb_valid_b),
    .i_wb_stall_a(o_wb_stall_a), .i_wb_stall_b(o_wb_stall_b)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic gwe,
    output logic o_arst_n
);

    initial begin
        gwe = 1'b0;
        forever #(HALF_PERIOD) gwe = ~gwe;
    end

    // reset is released on a falling edge, away from the state updates
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge gwe);
        @(negedge gwe);
        o_arst_n = 1'b1;
    end

endmodule

// ==== tb_lc4_core.sv ====
`timescale 1ns/10ps
module tb_lc4_core
    import lc4_isa_pkg::*, lc4_pipe_pkg::*;
();

    localparam word_t RESET_PC       = 16'h8200;
    localparam int    PROG_WORDS     = 512;
    localparam int    NUM_RETIRE     = 300;
    localparam int    RETIRE_TIMEOUT = 2000;
    localparam int    RESET_TIMEOUT  = 100;

    logic     gwe;
    logic     arst_n;
    word_t    cur_pc;
    word_t    insn_a;
    word_t    insn_b;
    logic     wb_valid_a, wb_valid_b, wb_we_a, wb_we_b;
    stall_e   wb_stall_a, wb_stall_b;
    word_t    wb_pc_a, wb_pc_b, wb_insn_a, wb_insn_b, wb_data_a, wb_data_b;
    reg_idx_t wb_wsel_a, wb_wsel_b;

    word_t    prog [PROG_WORDS];
    word_t    model_regs [NUM_REGS];
    integer   seed;
    int       retired;
    int       bubbles;

    tb_clock_gen u_clk (.gwe(gwe), .o_arst_n(arst_n));

    lc4_core_top dut (
        .i_arst_n(arst_n), .gwe(gwe), .o_cur_pc(cur_pc),
        .i_insn_a(insn_a), .i_insn_b(insn_b),
        .o_wb_valid_a(wb_valid_a), .o_wb_valid_b(wb_valid_b),
        .o_wb_stall_a(wb_stall_a), .o_wb_stall_b(wb_stall_b),
        .o_wb_pc_a(wb_pc_a), .o_wb_pc_b(wb_pc_b),
        .o_wb_insn_a(wb_insn_a), .o_wb_insn_b(wb_insn_b),
        .o_wb_we_a(wb_we_a), .o_wb_we_b(wb_we_b),
        .o_wb_wsel_a(wb_wsel_a), .o_wb_wsel_b(wb_wsel_b),
        .o_wb_data_a(wb_data_a), .o_wb_data_b(wb_data_b)
    );

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s, got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic watch_assertions();
        if (dut.u_chk.fail_count != 0) begin
            $display("a bound assertion on the core failed");
            stop_with_failure();
        end
    endtask

    // outside the program the fetch port returns a nop
    function automatic word_t fetch_word(input word_t addr);
        word_t off;
        off = addr - RESET_PC;
        if (off < PROG_WORDS) return prog[off];
        return 16'h0000;
    endfunction

    // only r0..r3 so that neighbours often depend on each other
    task automatic gen_program();
        int          i;
        int          kind;
        logic [31:0] bits;
        reg_idx_t    rd, rs, rt;
        for (i = 0; i < PROG_WORDS; i++) begin
            kind = $unsigned($random(seed)) % 10;
            bits = $random(seed);
            rd   = {1'b0, bits[1:0]};
            rs   = {1'b0, bits[3:2]};
            rt   = {1'b0, bits[5:4]};
            case (kind)
                0: prog[i] = {4'b0001, rd, rs, 3'b000, rt};
                1: prog[i] = {4'b0001, rd, rs, 3'b010, rt};
                2: prog[i] = {4'b0001, rd, rs, 1'b1, bits[20:16]};
                3: prog[i] = {4'b0101, rd, rs, 3'b000, rt};
                4: prog[i] = {4'b0101, rd, rs, 3'b010, rt};
                5: prog[i] = {4'b0101, rd, rs, 3'b011, rt};
                6: prog[i] = {4'b0101, rd, rs, 1'b1, bits[20:16]};
                7: prog[i] = {4'b1001, rd, bits[24:16]};
                8: prog[i] = {4'b1101, rd, 1'b1, bits[23:16]};
                default: prog[i] = 16'h0000;
            endcase
        end
    endtask

    // sequential ISA model, one instruction at a time
    task automatic model_step(input word_t insn, output logic we, output reg_idx_t rd,
                              output word_t val);
        word_t r1, r2, imm5, imm9;
        rd   = insn[11:9];
        r1   = model_regs[insn[8:6]];
        r2   = model_regs[insn[2:0]];
        imm5 = {{11{insn[4]}}, insn[4:0]};
        imm9 = {{7{insn[8]}}, insn[8:0]};
        we   = 1'b1;
        val  = 16'h0000;
        case (insn[15:12])
            4'b0001: begin
                if (insn[5]) val = r1 + imm5;
                else if (insn[5:3] == 3'b010) val = r1 - r2;
                else val = r1 + r2;
            end
            4'b0101: begin
                if (insn[5]) val = r1 & imm5;
                else if (insn[5:3] == 3'b010) val = r1 | r2;
                else if (insn[5:3] == 3'b011) val = r1 ^ r2;
                else val = r1 & r2;
            end
            4'b1001: val = imm9;
            // low byte kept, new high byte
            4'b1101: val = {insn[7:0], model_regs[rd][7:0]};
            default: we = 1'b0;
        endcase
        if (we) model_regs[rd] = val;
    endtask

    task automatic check_idle_trace(input string when);
        check_equal({when, ": wb valid a"}, wb_valid_a, 16'd0);
        check_equal({when, ": wb valid b"}, wb_valid_b, 16'd0);
        check_equal({when, ": wb stall a"}, wb_stall_a, STALL_EMPTY);
        check_equal({when, ": wb stall b"}, wb_stall_b, STALL_EMPTY);
        check_equal({when, ": wb we a"}, wb_we_a, 16'd0);
        check_equal({when, ": wb we b"}, wb_we_b, 16'd0);
    endtask

    task automatic retire_slot(input string slot, input word_t pc, input word_t insn,
                               input logic we, input reg_idx_t wsel, input word_t data);
        word_t    exp_pc;
        logic     exp_we;
        reg_idx_t exp_rd;
        word_t    exp_val;
        string    tag;
        exp_pc = RESET_PC + word_t'(retired);
        tag    = $sformatf("slot %s at pc %h", slot, exp_pc);
        check_equal({tag, " pc"}, pc, exp_pc);
        check_equal({tag, " insn"}, insn, prog[retired]);
        model_step(prog[retired], exp_we, exp_rd, exp_val);
        check_equal({tag, " write enable"}, we, exp_we);
        if (exp_we) begin
            check_equal({tag, " write select"}, wsel, exp_rd);
            check_equal({tag, " write data"}, data, exp_val);
        end
        retired++;
    endtask

    // pair at the current pc, driven away from the rising edge
    always @(negedge gwe) begin
        insn_a <= fetch_word(cur_pc);
        insn_b <= fetch_word(cur_pc + 16'd1);
    end

    initial begin
        int   i;
        int   cycles;
        int   idle;
        logic in_reset;
        seed    = 81;
        insn_a  = 16'h0000;
        insn_b  = 16'h0000;
        retired = 0;
        bubbles = 0;
        for (i = 0; i < NUM_REGS; i++) model_regs[i] = 16'h0000;
        gen_program();

        // reset level is sampled at the rising edge, outputs at the falling one
        cycles   = 0;
        in_reset = 1'b1;
        while (in_reset) begin
            @(posedge gwe);
            in_reset = !arst_n;
            @(negedge gwe);
            if (in_reset) begin
                check_equal("pc during reset", cur_pc, RESET_PC);
                check_idle_trace("during reset");
            end else begin
                check_idle_trace("after reset");
            end
            cycles++;
            if (in_reset && cycles >= RESET_TIMEOUT) begin
                $display("reset was not released within %0d cycles", RESET_TIMEOUT);
                stop_with_failure();
            end
        end

        // A retires before B in every cycle
        idle = 0;
        while (retired < NUM_RETIRE) begin
            @(negedge gwe);
            // a held B behind a valid A, not the start-up bubble
            if (wb_valid_a && wb_stall_b == STALL_SUPERSCALAR) bubbles++;
            if (wb_valid_a) retire_slot("A", wb_pc_a, wb_insn_a, wb_we_a, wb_wsel_a, wb_data_a);
            if (wb_valid_b) retire_slot("B", wb_pc_b, wb_insn_b, wb_we_b, wb_wsel_b, wb_data_b);
            watch_assertions();
            if (wb_valid_a || wb_valid_b) idle = 0;
            else idle++;
            if (idle >= RETIRE_TIMEOUT) begin
                $display("no instruction retired for %0d cycles", RETIRE_TIMEOUT);
                stop_with_failure();
            end
        end

        if (bubbles == 0) begin
            $display("slot B never showed a pipe-switch bubble");
            stop_with_failure();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== lc4_core.f ====
lc4_isa_pkg.sv
lc4_pipe_pkg.sv
lc4_decoder.sv
lc4_fetch_issue.sv
lc4_regfile_2w.sv
lc4_bypass_unit.sv
lc4_alu.sv
lc4_exec_pipe.sv
lc4_core_top.sv
lc4_core_chk.sv
tb_clock_gen.sv
tb_lc4_core.sv
